// File: Bender.yml
package:
  name: vga_ball

sources:
  - source/vga_ball_pkg.sv
  - source/raster_timing_gen.sv
  - source/ball_motion.sv
  - source/pixel_renderer.sv
  - source/vga_ball_top.sv
  - target: test
    files:
      - tb/vga_ball_checker.sv
      - tb/vga_ball_tb.sv

// File: source/ball_motion.sv
`timescale 1ns/1ps

module ball_motion
    import vga_ball_pkg::*;
#(
    parameter video_timing_t timing = vga_640x480
) (
    input  logic      ball_h_collide,
    input  logic      reset,
    input  logic      frame_tick,
    input  logic      stop,
    output ball_pos_t ball
);

    // far bounds so that the whole square stays on screen
    localparam coord_t h_limit = timing.h_active - ball_size;
    localparam coord_t v_limit = timing.v_active - ball_size;

    // axis index 0 is horizontal, 1 is vertical
    localparam int num_axes = 2;

    // far bound per axis, same index order as pos
    localparam coord_t [num_axes-1:0] limit = {v_limit, h_limit};

    coord_t pos      [num_axes];
    coord_t next_pos [num_axes];
    // set while the axis is moving toward 0
    logic   dir_neg  [num_axes];
    logic   step_en;

    // one step per frame, skipped while stop is held
    assign step_en = frame_tick && !stop;

    // candidate position after this frame's step
    always_comb begin
        for (int i = 0; i < num_axes; i++) begin
            if (dir_neg[i]) begin
                next_pos[i] = pos[i] - ball_step;
            end else begin
                next_pos[i] = pos[i] + ball_step;
            end
        end
    end

    // position and direction per axis
    // the new position takes effect from pixel (0,0) of the next frame
    always_ff @(posedge ball_h_collide or posedge reset) begin
        if (reset) begin
            for (int i = 0; i < num_axes; i++) begin
                pos[i]     <= '0;
                dir_neg[i] <= 1'b0;
            end
        end else if (step_en) begin
            for (int i = 0; i < num_axes; i++) begin
                pos[i] <= next_pos[i];
                // bounce exactly on the bound the step lands on
                if (next_pos[i] == limit[i]) begin
                    dir_neg[i] <= 1'b1;
                end else if (next_pos[i] == '0) begin
                    dir_neg[i] <= 1'b0;
                end
            end
        end
    end

    assign ball.h = pos[0];
    assign ball.v = pos[1];

endmodule

// File: source/pixel_renderer.sv
`timescale 1ns/1ps

module pixel_renderer
    import vga_ball_pkg::*;
(
    input  logic      ball_h_collide,
    input  logic      reset,
    input  beam_t     beam,
    input  ball_pos_t ball,
    output logic      hsync,
    output logic      vsync,
    output rgb_t      rgb
);

    coord_t hdiff;
    coord_t vdiff;
    logic   hband;
    logic   vband;
    logic   ball_gfx;
    logic   grid_gfx;
    logic   red;
    logic   green;
    logic   blue;

    // beam offset from the ball corner
    // wraps modulo 1024, so only the four columns or rows from the corner on are small
    assign hdiff = beam.hpos - ball.h;
    assign vdiff = beam.vpos - ball.v;

    // column band and row band through the ball
    assign hband = (hdiff < ball_size);
    assign vband = (vdiff < ball_size);

    // ball square is where the two bands cross
    assign ball_gfx = hband && vband;

    // dot every eight pixels in both directions
    assign grid_gfx = ((beam.hpos & grid_mask) == '0) && ((beam.vpos & grid_mask) == '0);

    // nothing is lit during blanking
    assign red   = beam.display_on && hband;
    assign green = beam.display_on && (grid_gfx || ball_gfx);
    assign blue  = beam.display_on && vband;

    // single output stage
    // the sync levels ride along so all three pins show the same pixel
    always_ff @(posedge ball_h_collide or posedge reset) begin
        if (reset) begin
            rgb   <= '0;
            hsync <= 1'b1;
            vsync <= 1'b1;
        end else begin
            rgb   <= {blue, green, red};
            hsync <= beam.hsync;
            vsync <= beam.vsync;
        end
    end

endmodule

// File: source/raster_timing_gen.sv
`timescale 1ns/1ps

module raster_timing_gen
    import vga_ball_pkg::*;
#(
    parameter video_timing_t timing = vga_640x480
) (
    input  logic  ball_h_collide,
    input  logic  reset,
    output beam_t beam,
    output logic  frame_tick
);

    // full line and full frame lengths, blanking included
    localparam coord_t h_total = timing.h_active + timing.h_front
                               + timing.h_sync + timing.h_back;
    localparam coord_t v_total = timing.v_active + timing.v_front
                               + timing.v_sync + timing.v_back;

    // sync pulse window, start inclusive and end exclusive
    localparam coord_t hsync_start = timing.h_active + timing.h_front;
    localparam coord_t hsync_end   = hsync_start + timing.h_sync;
    localparam coord_t vsync_start = timing.v_active + timing.v_front;
    localparam coord_t vsync_end   = vsync_start + timing.v_sync;

    coord_t hcount;
    coord_t vcount;
    logic   line_end;
    logic   frame_end;

    // last pixel of a line and last line of a frame
    assign line_end  = (hcount == h_total - 10'd1);
    assign frame_end = (vcount == v_total - 10'd1);

    // beam counters
    // pixel 0 sits at (0,0) straight out of reset
    always_ff @(posedge ball_h_collide or posedge reset) begin
        if (reset) begin
            hcount <= '0;
            vcount <= '0;
        end else begin
            if (line_end) begin
                hcount <= '0;
                // vertical count only moves when the line wraps
                if (frame_end) begin
                    vcount <= '0;
                end else begin
                    vcount <= vcount + 10'd1;
                end
            end else begin
                hcount <= hcount + 10'd1;
            end
        end
    end

    // everything below is decoded straight from the counters
    assign beam.hpos = hcount;
    assign beam.vpos = vcount;

    // low only inside the pulse window
    assign beam.hsync = !((hcount >= hsync_start) && (hcount < hsync_end));
    assign beam.vsync = !((vcount >= vsync_start) && (vcount < vsync_end));

    assign beam.display_on = (hcount < timing.h_active) && (vcount < timing.v_active);

    // one cycle at the very last pixel, the motion unit steps on it
    assign frame_tick = line_end && frame_end;

endmodule

// File: source/vga_ball_pkg.sv
package vga_ball_pkg;

    // beam or ball coordinate, 1024 positions per axis
    typedef logic [9:0] coord_t;

    // pixel colour, blue in the msb, green in the middle, red in the lsb
    typedef logic [2:0] rgb_t;

    // one raster mode
    // active area first, then the blanking parts in the order the beam meets them
    typedef struct packed {
        coord_t h_active;
        coord_t h_front;
        coord_t h_sync;
        coord_t h_back;
        coord_t v_active;
        coord_t v_front;
        coord_t v_sync;
        coord_t v_back;
    } video_timing_t;

    // standard 640x480 at a 25 MHz pixel clock
    localparam video_timing_t vga_640x480 = '{
        h_active: 10'd640,
        h_front:  10'd16,
        h_sync:   10'd96,
        h_back:   10'd48,
        v_active: 10'd480,
        v_front:  10'd10,
        v_sync:   10'd2,
        v_back:   10'd33
    };

    // beam state as seen by the renderer
    // sync levels are active low
    typedef struct packed {
        coord_t hpos;
        coord_t vpos;
        logic   hsync;
        logic   vsync;
        logic   display_on;
    } beam_t;

    // top left corner of the ball square
    typedef struct packed {
        coord_t h;
        coord_t v;
    } ball_pos_t;

    // side of the ball square, also the width of both bands
    localparam coord_t ball_size = 10'd4;
    // pixels moved per frame on each axis
    localparam coord_t ball_step = 10'd2;
    // a grid dot sits where these low bits of both coordinates are zero
    localparam coord_t grid_mask = 10'd7;

endpackage

// File: source/vga_ball_top.sv
`timescale 1ns/1ps

module vga_ball_top
    import vga_ball_pkg::*;
#(
    parameter video_timing_t timing = vga_640x480
) (
    input  logic ball_h_collide,
    input  logic reset,
    input  logic stop,
    output logic hsync,
    output logic vsync,
    output rgb_t rgb
);

    beam_t     beam;
    logic      frame_tick;
    ball_pos_t ball;

    // beam counters and sync decode
    raster_timing_gen #(
        .timing (timing)
    ) i_raster_timing_gen (
        .ball_h_collide (ball_h_collide),
        .reset          (reset),
        .beam           (beam),
        .frame_tick     (frame_tick)
    );

    // ball steps once per frame, stop freezes it
    ball_motion #(
        .timing (timing)
    ) i_ball_motion (
        .ball_h_collide (ball_h_collide),
        .reset          (reset),
        .frame_tick     (frame_tick),
        .stop           (stop),
        .ball           (ball)
    );

    // colour and sync pins, one cycle behind the counters
    pixel_renderer i_pixel_renderer (
        .ball_h_collide (ball_h_collide),
        .reset          (reset),
        .beam           (beam),
        .ball           (ball),
        .hsync          (hsync),
        .vsync          (vsync),
        .rgb            (rgb)
    );

endmodule

// File: tb/vga_ball_checker.sv
`timescale 1ns/1ps

module vga_ball_checker
    import vga_ball_pkg::*;
#(
    parameter video_timing_t timing = vga_640x480
) (
    input logic      ball_h_collide,
    input logic      reset,
    input logic      frame_tick,
    input ball_pos_t ball,
    input logic      hsync,
    input logic      vsync,
    input rgb_t      rgb
);

    // far bounds of the ball corner
    localparam coord_t h_limit = timing.h_active - ball_size;
    localparam coord_t v_limit = timing.v_active - ball_size;

    // number of assertion failures so far
    int error_count = 0;

    // end of frame tick is one pixel wide
    tick_single: assert property (@(posedge ball_h_collide) disable iff (reset)
        frame_tick |=> !frame_tick)
        else begin
            error_count++;
            $error("frame_tick stayed high for two cycles");
        end

    // ball square never leaves the active area
    ball_in_range: assert property (@(posedge ball_h_collide) disable iff (reset)
        (ball.h <= h_limit) && (ball.v <= v_limit))
        else begin
            error_count++;
            $error("ball position beyond its limit");
        end

    // sync pulses sit in blanking, so no colour with them
    dark_in_sync: assert property (@(posedge ball_h_collide) disable iff (reset)
        (!hsync || !vsync) |-> (rgb == '0))
        else begin
            error_count++;
            $error("rgb lit while a sync level is low");
        end

endmodule

bind vga_ball_top vga_ball_checker #(
    .timing (timing)
) i_vga_ball_checker (
    .ball_h_collide (ball_h_collide),
    .reset          (reset),
    .frame_tick     (frame_tick),
    .ball           (ball),
    .hsync          (hsync),
    .vsync          (vsync),
    .rgb            (rgb)
);

// File: tb/vga_ball_tb.sv
`timescale 1ns/1ps

module vga_ball_tb
    import vga_ball_pkg::*;
();

    // small raster so that both axes bounce within a few dozen frames
    localparam int hact = 40;
    localparam int hfp  = 2;
    localparam int hsw  = 4;
    localparam int hbp  = 4;
    localparam int vact = 24;
    localparam int vfp  = 1;
    localparam int vsw  = 2;
    localparam int vbp  = 3;
    localparam int h_total = hact + hfp + hsw + hbp;
    localparam int v_total = vact + vfp + vsw + vbp;
    localparam int frame_cycles = h_total * v_total;
    // ball square side and step per frame
    localparam int square = 4;
    localparam int step = 2;
    localparam int h_limit = hact - square;
    localparam int v_limit = vact - square;
    // 40 moving frames, 20 stop frames, a partial frame and 3 more, rounded up
    localparam int timeout_cycles = 80 * frame_cycles;

    localparam video_timing_t small_timing = '{
        h_active: coord_t'(hact),
        h_front:  coord_t'(hfp),
        h_sync:   coord_t'(hsw),
        h_back:   coord_t'(hbp),
        v_active: coord_t'(vact),
        v_front:  coord_t'(vfp),
        v_sync:   coord_t'(vsw),
        v_back:   coord_t'(vbp)
    };

    logic ball_h_collide;
    logic reset;
    logic stop;
    logic hsync;
    logic vsync;
    rgb_t rgb;

    // model state, beam position and ball per axis
    int         beam_h;
    int         beam_v;
    int         ball_h;
    int         ball_v;
    bit         ball_h_neg;
    bit         ball_v_neg;
    // what the output register should hold right now
    logic       exp_hsync;
    logic       exp_vsync;
    logic [2:0] exp_rgb;
    int         frames_seen;
    int         cycle_count;
    // round trip markers for the free running phase, taken from the DUT ball
    bit         h_hit_limit;
    bit         h_back_home;
    bit         v_hit_limit;
    bit         v_back_home;

    vga_ball_top #(
        .timing (small_timing)
    ) i_vga_ball_top (
        .ball_h_collide (ball_h_collide),
        .reset          (reset),
        .stop           (stop),
        .hsync          (hsync),
        .vsync          (vsync),
        .rgb            (rgb)
    );

    always #20 ball_h_collide = ~ball_h_collide;

    task automatic stop_with_failure(input string reason);
        $display("%s", reason);
        $display("RESULT: FAIL");
        $fatal(1);
    endtask

    task automatic check_value(input string what, input logic [9:0] actual,
                               input logic [9:0] expected);
        if (actual !== expected) begin
            $display("** Error at %0t: %s is %0h, expected %0h", $time, what, actual, expected);
            stop_with_failure("DUT output does not match the reference model");
        end
    endtask

    // expected {hsync, vsync, rgb} for one beam position and ball corner
    function automatic logic [4:0] expected_pixel(input int h, input int v,
                                                  input int bh, input int bv);
        int       hdiff;
        int       vdiff;
        logic     display_on;
        logic     hband;
        logic     vband;
        logic     grid;
        logic     hs;
        logic     vs;
        logic     red;
        logic     green;
        logic     blue;
        // differences wrap at 1024 like the 10 bit coordinates
        hdiff = (h - bh + 1024) % 1024;
        vdiff = (v - bv + 1024) % 1024;
        display_on = (h < hact) && (v < vact);
        hband = (hdiff < square);
        vband = (vdiff < square);
        grid = (h % 8 == 0) && (v % 8 == 0);
        // sync is active low inside the pulse window
        hs = !((h >= hact + hfp) && (h < hact + hfp + hsw));
        vs = !((v >= vact + vfp) && (v < vact + vfp + vsw));
        red = display_on && hband;
        green = display_on && (grid || (hband && vband));
        blue = display_on && vband;
        return {hs, vs, blue, green, red};
    endfunction

    task automatic move_axis(inout int pos, inout bit neg, input int limit);
        if (neg) begin
            pos = pos - step;
        end else begin
            pos = pos + step;
        end
        if (pos == limit) begin
            neg = 1'b1;
        end else if (pos == 0) begin
            neg = 1'b0;
        end
    endtask

    task automatic reset_model();
        beam_h = 0;
        beam_v = 0;
        ball_h = 0;
        ball_v = 0;
        ball_h_neg = 1'b0;
        ball_v_neg = 1'b0;
        exp_hsync = 1'b1;
        exp_vsync = 1'b1;
        exp_rgb = 3'b000;
    endtask

    // last pixel of the frame, ball steps unless stop is held
    task automatic end_of_frame();
        frames_seen++;
        if (!stop) begin
            move_axis(ball_h, ball_h_neg, h_limit);
            move_axis(ball_v, ball_v_neg, v_limit);
        end
    endtask

    // DUT ball has to reach each far bound and come back to 0
    task automatic note_ball_position();
        if (i_vga_ball_top.ball.h == h_limit) begin
            h_hit_limit = 1'b1;
        end
        if (h_hit_limit && i_vga_ball_top.ball.h == 0) begin
            h_back_home = 1'b1;
        end
        if (i_vga_ball_top.ball.v == v_limit) begin
            v_hit_limit = 1'b1;
        end
        if (v_hit_limit && i_vga_ball_top.ball.v == 0) begin
            v_back_home = 1'b1;
        end
    endtask

    // one rising edge: register loads the current pixel, beam moves on
    task automatic advance_model();
        logic [4:0] px;
        px = expected_pixel(beam_h, beam_v, ball_h, ball_v);
        exp_hsync = px[4];
        exp_vsync = px[3];
        exp_rgb = px[2:0];
        if (beam_h == h_total - 1) begin
            beam_h = 0;
            if (beam_v == v_total - 1) begin
                beam_v = 0;
                end_of_frame();
            end else begin
                beam_v++;
            end
        end else begin
            beam_h++;
        end
    endtask

    // compare on the falling edge, pins and stop are settled there
    always @(negedge ball_h_collide) begin
        if (reset) reset_model();
        check_value("rgb", rgb, exp_rgb);
        check_value("hsync", hsync, exp_hsync);
        check_value("vsync", vsync, exp_vsync);
        if (!reset) note_ball_position();
        if (!reset) advance_model();
    end

    // bound assertions count their failures, the first one ends the run
    always @(i_vga_ball_top.i_vga_ball_checker.error_count) begin
        if (i_vga_ball_top.i_vga_ball_checker.error_count != 0) begin
            stop_with_failure("an assertion in the bound checker failed");
        end
    end

    always @(posedge ball_h_collide) begin
        cycle_count++;
        if (cycle_count >= timeout_cycles) begin
            stop_with_failure("test timed out before all phases finished");
        end
    end

    // returns 1 ns after the edge that starts the next frame
    task run_frames(input int count);
        int start;
        repeat (count) begin
            start = frames_seen;
            wait (frames_seen != start);
            @(posedge ball_h_collide);
            #1;
        end
    endtask

    initial begin
        int unsigned draw;
        ball_h_collide = 1'b0;
        reset = 1'b1;
        stop = 1'b0;
        frames_seen = 0;
        cycle_count = 0;
        reset_model();
        draw = $urandom(32'h2eec);
        repeat (4) @(posedge ball_h_collide);
        #1;
        reset = 1'b0;

        // free running, two round trips vertically and one horizontally
        run_frames(40);
        if (!(h_hit_limit && h_back_home && v_hit_limit && v_back_home)) begin
            stop_with_failure("ball did not bounce off both limits and back to 0");
        end

        // random stop level per frame
        for (int i = 0; i < 20; i++) begin
            draw = $urandom;
            stop = draw[0];
            run_frames(1);
        end
        stop = 1'b0;

        // reset pulse in the middle of a frame
        repeat (frame_cycles / 2 + 17) @(posedge ball_h_collide);
        #1;
        reset = 1'b1;
        repeat (3) @(posedge ball_h_collide);
        #1;
        reset = 1'b0;
        run_frames(3);
        repeat (2) @(posedge ball_h_collide);
        #1;

        if (i_vga_ball_top.i_vga_ball_checker.error_count != 0) begin
            stop_with_failure("an assertion in the bound checker failed");
        end else begin
            $display("RESULT: PASS");
            $finish;
        end
    end

endmodule

// File: vga_ball_top.f
source/vga_ball_pkg.sv
source/raster_timing_gen.sv
source/ball_motion.sv
source/pixel_renderer.sv
source/vga_ball_top.sv
tb/vga_ball_checker.sv
tb/vga_ball_tb.sv
